// ==== bt_arq_pkg.sv ====
// ****************************************
// shared types for the BR baseband ARQ and
// flow-control block
// ****************************************
package bt_arq_pkg;

  typedef logic [2:0] lt_addr_t;

  // baseband packet type field of the header
  typedef enum logic [3:0] {
    PT_NULL = 4'h0,
    PT_POLL = 4'h1,
    PT_FHS  = 4'h2,
    PT_DM1  = 4'h3,
    PT_DH1  = 4'h4,
    PT_HV1  = 4'h5,
    PT_HV2  = 4'h6,
    PT_HV3  = 4'h7,
    PT_DV   = 4'h8,
    PT_AUX1 = 4'h9,
    PT_DM3  = 4'ha,
    PT_DH3  = 4'hb,
    PT_EV4  = 4'hc,
    PT_EV5  = 4'hd,
    PT_DM5  = 4'he,
    PT_DH5  = 4'hf
  } pkt_type_t;

  // one entry per logical transport
  typedef struct packed {
    logic seqn_old;
    logic arqn;
    logic tx_seqn;
    logic src_flow;
  } link_entry_t;

  // value after reset and after a new connection
  localparam link_entry_t NEW_CONN_ENTRY = '{
    seqn_old: 1'b0,
    arqn:     1'b0,
    tx_seqn:  1'b1,
    src_flow: 1'b1
  };

  typedef struct packed {
    lt_addr_t  lt_addr;
    pkt_type_t pktype;
    logic      seqn;
    logic      cac_ok;
    logic      hec_ok;
    logic      addressed;
  } rx_header_t;

  typedef enum logic [1:0] {RX_NONE, RX_ACCEPT, RX_IGNORE, RX_REJECT} rx_verdict_t;

  typedef struct packed {
    logic        valid;
    lt_addr_t    lt_addr;
    rx_verdict_t verdict;
    logic        arqn;
    logic        seqn_old;
  } rx_result_t;

  typedef enum logic [1:0] {TX_NONE, TX_NEW, TX_OLD, TX_ZERO} tx_choice_t;

  typedef struct packed {
    logic       valid;
    lt_addr_t   lt_addr;
    tx_choice_t choice;
    logic       seqn;
    logic       arqn;
    logic       src_flow;
  } tx_result_t;

  // one access to the link-state table
  typedef struct packed {
    lt_addr_t    addr;
    logic        we;
    link_entry_t wdata;
  } tbl_req_t;

  // ACL packets that carry a sequenced payload
  function automatic logic is_acl_data(input pkt_type_t pt);
    case (pt)
      PT_DM1, PT_DH1, PT_DV, PT_DM3, PT_DH3, PT_DM5, PT_DH5: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // packets that take no part in ACL sequencing
  function automatic logic is_no_payload_seq(input pkt_type_t pt);
    case (pt)
      PT_NULL, PT_POLL, PT_HV1, PT_HV2, PT_HV3, PT_AUX1: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// ==== link_state_table.sv ====
// ****************************************
// per-link ARQ state, one combinational
// read port and one clocked write port
// ****************************************
module link_state_table
  import bt_arq_pkg::*;
#(
  parameter int NUM_LINKS = 8
)
(
  input  logic        clk_6M,
  input  logic        rstz,
  input  tbl_req_t    tbl_req,
  output link_entry_t rd_entry
);

  link_entry_t entry [NUM_LINKS];
  logic        in_range;

  // addresses above the configured link count read as a fresh link
  assign in_range = 32'(tbl_req.addr) < NUM_LINKS;

  assign rd_entry = in_range ? entry[tbl_req.addr] : NEW_CONN_ENTRY;

  // every link starts out as a new connection
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      for (int i = 0; i < NUM_LINKS; i++)
      begin
        entry[i] <= NEW_CONN_ENTRY;
      end
    end
    else if (tbl_req.we && in_range)
    begin
      entry[tbl_req.addr] <= tbl_req.wdata;
    end
  end

endmodule

// ==== link_state_arbiter.sv ====
// ****************************************
// fixed-priority access to the link table,
// RX controller ahead of TX controller
// ****************************************
module link_state_arbiter
  import bt_arq_pkg::*;
(
  input  logic     rx_req,
  input  tbl_req_t rx_tbl_req,
  input  logic     tx_req,
  input  tbl_req_t tx_tbl_req,
  output logic     rx_gnt,
  output logic     tx_gnt,
  output tbl_req_t tbl_req
);

  // rx decisions are tied to header and payload timing and cannot wait
  assign rx_gnt = rx_req;
  assign tx_gnt = tx_req & ~rx_req;

  always_comb
  begin
    if (rx_gnt)
    begin
      tbl_req = rx_tbl_req;
    end
    else if (tx_gnt)
    begin
      tbl_req = tx_tbl_req;
    end
    else
    begin
      // idle port, read of link 0 and no write
      tbl_req = '0;
    end
  end

endmodule

// ==== rx_arq_ctrl.sv ====
// ****************************************
// receive ARQ: accept, ignore or reject per
// packet, ARQN update, slave response gate
// ****************************************
module rx_arq_ctrl
  import bt_arq_pkg::*;
(
  input  logic        clk_6M,
  input  logic        rstz,
  input  logic        hdr_p,
  input  rx_header_t  hdr,
  input  logic        py_end_p,
  input  logic        crc_ok,
  input  logic        mic_ok,
  input  logic        new_conn_p,
  input  lt_addr_t    new_conn_addr,
  input  logic        is_master,
  input  logic        rx_slot_end_p,
  output tbl_req_t    tbl_req,
  output logic        req,
  input  logic        gnt,
  input  link_entry_t rd_entry,
  output rx_result_t  rx_result,
  output logic        ms_acltxcmd_p
);

  typedef enum logic [1:0] {S_IDLE, S_PY_WAIT, S_CLR_WALK} rx_state_t;

  rx_state_t   state;
  lt_addr_t    walk_addr;
  lt_addr_t    py_addr;
  logic        py_seqn;
  logic        nc_pend;
  lt_addr_t    nc_addr;
  logic        slot_sup;

  logic        take_hdr;
  logic        take_py;
  logic        nc_go;
  logic        hdr_fail;
  logic        hdr_data;
  logic        hdr_noseq;
  logic        seqn_new;
  logic        sup_now;
  logic        go_py;
  logic        go_walk;
  logic        report;
  logic        acc_we;
  lt_addr_t    acc_addr;
  link_entry_t wentry;
  rx_verdict_t verdict;

  // a header during the payload wait replaces the pending payload
  assign take_hdr = hdr_p & ((state == S_IDLE) | ((state == S_PY_WAIT) & ~py_end_p));
  assign take_py  = py_end_p & (state == S_PY_WAIT);
  assign nc_go    = nc_pend & ~take_hdr & ~take_py & (state != S_CLR_WALK);

  assign hdr_fail  = ~hdr.cac_ok | ~hdr.hec_ok;
  assign hdr_data  = is_acl_data(hdr.pktype);
  assign hdr_noseq = is_no_payload_seq(hdr.pktype);
  assign seqn_new  = hdr.seqn != rd_entry.seqn_old;

  assign go_walk = take_hdr & hdr_fail & ~is_master;
  assign go_py   = take_hdr & ~hdr_fail & hdr.addressed & hdr_data & seqn_new;

  // slave must not answer after a failed or foreign header
  assign sup_now       = take_hdr & ~is_master & (hdr_fail | ~hdr.addressed);
  assign ms_acltxcmd_p = rx_slot_end_p & ~slot_sup & ~sup_now;

  // read-modify-write of one entry in the grant cycle
  always_comb
  begin
    req      = 1'b0;
    acc_addr = hdr.lt_addr;
    acc_we   = 1'b0;
    wentry   = rd_entry;
    verdict  = RX_NONE;
    report   = 1'b0;
    if (state == S_CLR_WALK)
    begin
      req      = 1'b1;
      acc_addr = walk_addr;
      acc_we   = 1'b1;
      wentry.arqn = 1'b0;
    end
    else if (take_py)
    begin
      req      = 1'b1;
      acc_addr = py_addr;
      acc_we   = 1'b1;
      report   = 1'b1;
      if (crc_ok & mic_ok)
      begin
        verdict         = RX_ACCEPT;
        wentry.arqn     = 1'b1;
        wentry.seqn_old = py_seqn;
      end
      else
      begin
        verdict     = RX_REJECT;
        wentry.arqn = 1'b0;
      end
    end
    else if (take_hdr)
    begin
      req = 1'b1;
      // new data payload waits for the payload end, nothing reported yet
      report = ~go_py;
      if (hdr_fail)
      begin
        acc_we      = 1'b1;
        wentry.arqn = 1'b0;
        verdict     = RX_REJECT;
      end
      else if (hdr.addressed & hdr_data & ~seqn_new)
      begin
        acc_we      = 1'b1;
        wentry.arqn = 1'b1;
        verdict     = RX_IGNORE;
      end
      else if (hdr.addressed & hdr_noseq & seqn_new)
      begin
        acc_we      = 1'b1;
        wentry.arqn = 1'b0;
        verdict     = RX_REJECT;
      end
    end
    else if (nc_go)
    begin
      req      = 1'b1;
      acc_addr = nc_addr;
      acc_we   = 1'b1;
      wentry   = NEW_CONN_ENTRY;
    end
  end

  assign tbl_req = '{addr: acc_addr, we: acc_we & gnt, wdata: wentry};

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state     <= S_IDLE;
      walk_addr <= '0;
      nc_pend   <= 1'b0;
      slot_sup  <= 1'b0;
      rx_result <= '0;
    end
    else
    begin
      rx_result <= '{valid: report & gnt, lt_addr: acc_addr, verdict: verdict,
                     arqn: wentry.arqn, seqn_old: wentry.seqn_old};
      case (state)
        S_CLR_WALK:
        begin
          // eight writes, wraps back to link 0
          if (gnt)
          begin
            walk_addr <= walk_addr + 3'd1;
            if (walk_addr == 3'd7)
              state <= S_IDLE;
          end
        end
        default:
        begin
          if (gnt & go_walk)
          begin
            state     <= S_CLR_WALK;
            walk_addr <= '0;
          end
          else if (gnt & go_py)
            state <= S_PY_WAIT;
          else if (gnt & (take_py | take_hdr))
            state <= S_IDLE;
        end
      endcase
      if (new_conn_p)
        nc_pend <= 1'b1;
      else if (nc_go & gnt)
        nc_pend <= 1'b0;
      // held until the receive slot closes
      if (rx_slot_end_p)
        slot_sup <= 1'b0;
      else if (sup_now)
        slot_sup <= 1'b1;
    end
  end

  // header and connection fields kept for the later table write
  always_ff @(posedge clk_6M)
  begin
    if (go_py & gnt)
    begin
      py_addr <= hdr.lt_addr;
      py_seqn <= hdr.seqn;
    end
    if (new_conn_p)
      nc_addr <= new_conn_addr;
  end

endmodule

// ==== tx_arq_ctrl.sv ====
// ****************************************
// transmit ARQ: new or old payload, SEQN
// toggle and source flow bit per link
// ****************************************
module tx_arq_ctrl
  import bt_arq_pkg::*;
(
  input  logic        clk_6M,
  input  logic        rstz,
  input  logic        tx_slot_p,
  input  lt_addr_t    tx_lt_addr,
  input  pkt_type_t   tx_pktype,
  input  logic [7:0]  rx_arqn_vec,
  input  logic [7:0]  rx_flow_vec,
  output tbl_req_t    tbl_req,
  output logic        req,
  input  logic        gnt,
  input  link_entry_t rd_entry,
  output tx_result_t  tx_result
);

  logic        pend;
  lt_addr_t    s_addr;
  pkt_type_t   s_pktype;
  logic        s_arqn;
  logic        s_flow;

  logic        s_data;
  tx_choice_t  choice;
  link_entry_t wentry;

  assign s_data = is_acl_data(s_pktype);

  // data goes out fresh only on ACK with the peer's flow on;
  // TX_ZERO needs a flush request and is never chosen
  assign choice = (~s_data | (s_arqn & s_flow)) ? TX_NEW : TX_OLD;

  always_comb
  begin
    wentry = rd_entry;
    if (s_data && (choice == TX_NEW))
      wentry.tx_seqn = ~rd_entry.tx_seqn;
    // flow is only meaningful on ACL data
    wentry.src_flow = s_flow | ~s_data;
  end

  assign req     = pend;
  assign tbl_req = '{addr: s_addr, we: pend & gnt, wdata: wentry};

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      pend      <= 1'b0;
      tx_result <= '0;
    end
    else
    begin
      // header SEQN is the value before the toggle
      tx_result <= '{valid: pend & gnt, lt_addr: s_addr, choice: choice,
                     seqn: rd_entry.tx_seqn, arqn: rd_entry.arqn,
                     src_flow: wentry.src_flow};
      if (pend & gnt)
        pend <= 1'b0;
      else if (tx_slot_p)
        pend <= 1'b1;
    end
  end

  // slot inputs frozen while waiting for the port
  always_ff @(posedge clk_6M)
  begin
    if (tx_slot_p & ~pend)
    begin
      s_addr   <= tx_lt_addr;
      s_pktype <= tx_pktype;
      s_arqn   <= rx_arqn_vec[tx_lt_addr];
      s_flow   <= rx_flow_vec[tx_lt_addr];
    end
  end

endmodule

// ==== arq_flow_top.sv ====
// ****************************************
// ARQ and flow control for up to eight
// logical transports of a BR link
// ****************************************
module arq_flow_top
  import bt_arq_pkg::*;
#(
  parameter int NUM_LINKS = 8
)
(
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       hdr_p,
  input  rx_header_t hdr,
  input  logic       py_end_p,
  input  logic       crc_ok,
  input  logic       mic_ok,
  input  logic       is_master,
  input  logic       rx_slot_end_p,
  input  logic       tx_slot_p,
  input  lt_addr_t   tx_lt_addr,
  input  pkt_type_t  tx_pktype,
  input  logic [7:0] rx_arqn_vec,
  input  logic [7:0] rx_flow_vec,
  input  logic       aclrx_buf_empty,
  input  logic       new_conn_p,
  input  lt_addr_t   new_conn_addr,
  output rx_result_t rx_result,
  output tx_result_t tx_result,
  output logic       ms_acltxcmd_p,
  output logic       rsp_flow
);

  tbl_req_t    rx_tbl_req;
  tbl_req_t    tx_tbl_req;
  tbl_req_t    tbl_req;
  logic        rx_req;
  logic        tx_req;
  logic        rx_gnt;
  logic        tx_gnt;
  link_entry_t rd_entry;

  // destination flow, stop the peer while the receive buffer is full
  assign rsp_flow = aclrx_buf_empty;

  rx_arq_ctrl u_rx_arq_ctrl (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .hdr_p         (hdr_p),
    .hdr           (hdr),
    .py_end_p      (py_end_p),
    .crc_ok        (crc_ok),
    .mic_ok        (mic_ok),
    .new_conn_p    (new_conn_p),
    .new_conn_addr (new_conn_addr),
    .is_master     (is_master),
    .rx_slot_end_p (rx_slot_end_p),
    .tbl_req       (rx_tbl_req),
    .req           (rx_req),
    .gnt           (rx_gnt),
    .rd_entry      (rd_entry),
    .rx_result     (rx_result),
    .ms_acltxcmd_p (ms_acltxcmd_p)
  );

  tx_arq_ctrl u_tx_arq_ctrl (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .tx_slot_p   (tx_slot_p),
    .tx_lt_addr  (tx_lt_addr),
    .tx_pktype   (tx_pktype),
    .rx_arqn_vec (rx_arqn_vec),
    .rx_flow_vec (rx_flow_vec),
    .tbl_req     (tx_tbl_req),
    .req         (tx_req),
    .gnt         (tx_gnt),
    .rd_entry    (rd_entry),
    .tx_result   (tx_result)
  );

  link_state_arbiter u_link_state_arbiter (
    .rx_req     (rx_req),
    .rx_tbl_req (rx_tbl_req),
    .tx_req     (tx_req),
    .tx_tbl_req (tx_tbl_req),
    .rx_gnt     (rx_gnt),
    .tx_gnt     (tx_gnt),
    .tbl_req    (tbl_req)
  );

  link_state_table #(
    .NUM_LINKS (NUM_LINKS)
  ) u_link_state_table (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .tbl_req  (tbl_req),
    .rd_entry (rd_entry)
  );

endmodule

// ==== arq_flow_assertions.sv ====
// ****************************************
// bound checks on table arbitration and
// table write addresses
// ****************************************
module arq_flow_assertions
  import bt_arq_pkg::*;
#(
  parameter int NUM_LINKS = 8
)
(
  input logic     clk_6M,
  input logic     rstz,
  input logic     rx_req,
  input logic     tx_req,
  input logic     rx_gnt,
  input logic     tx_gnt,
  input tbl_req_t tbl_req
);

  // one owner of the table port at a time
  a_one_grant : assert property (@(posedge clk_6M) disable iff (!rstz)
    !(rx_gnt && tx_gnt))
    else $error("arbiter granted rx and tx together");

  a_rx_gnt_req : assert property (@(posedge clk_6M) disable iff (!rstz)
    rx_gnt |-> rx_req)
    else $error("rx grant without rx request");

  a_tx_gnt_req : assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_gnt |-> tx_req)
    else $error("tx grant without tx request");

  // rx timing is fixed by the air interface
  a_rx_first : assert property (@(posedge clk_6M) disable iff (!rstz)
    rx_req |-> rx_gnt)
    else $error("rx request was not granted");

  a_wr_addr : assert property (@(posedge clk_6M) disable iff (!rstz)
    tbl_req.we |-> (32'(tbl_req.addr) < NUM_LINKS))
    else $error("table write to link %0d out of range", tbl_req.addr);

endmodule

bind arq_flow_top arq_flow_assertions #(
  .NUM_LINKS (NUM_LINKS)
) u_arq_flow_assertions (
  .clk_6M  (clk_6M),
  .rstz    (rstz),
  .rx_req  (rx_req),
  .tx_req  (tx_req),
  .rx_gnt  (rx_gnt),
  .tx_gnt  (tx_gnt),
  .tbl_req (tbl_req)
);

// ==== tb_arq_flow.sv ====
// ****************************************
// testbench for the ARQ and flow block,
// file-driven events against a link model
// ****************************************
module tb_arq_flow
  import bt_arq_pkg::*;
();

  // one line of the event file
  typedef struct packed {
    logic [3:0] kind;
    logic [2:0] addr;
    logic [3:0] pkt;
    logic       seqn;
    logic       f1;
    logic       f2;
    logic       f3;
    logic       f4;
    logic       f5;
    logic       master;
    logic [1:0] exp;
  } stim_t;

  logic       clk_6M;
  logic       rstz;
  logic       hdr_p;
  rx_header_t hdr;
  logic       py_end_p;
  logic       crc_ok;
  logic       mic_ok;
  logic       is_master;
  logic       rx_slot_end_p;
  logic       tx_slot_p;
  lt_addr_t   tx_lt_addr;
  pkt_type_t  tx_pktype;
  logic [7:0] rx_arqn_vec;
  logic [7:0] rx_flow_vec;
  logic       aclrx_buf_empty;
  logic       new_conn_p;
  lt_addr_t   new_conn_addr;
  rx_result_t rx_result;
  tx_result_t tx_result;
  logic       ms_acltxcmd_p;
  logic       rsp_flow;

  link_entry_t model [8];
  stim_t       ev [128];
  int          n_ev;
  int          errors;
  int          checks;
  logic        sup_ref;
  rx_result_t  rx_exp;
  tx_result_t  tx_exp;
  int          rx_seen;
  int          tx_seen;

  always #50 clk_6M = ~clk_6M;

  arq_flow_top #(
    .NUM_LINKS (8)
  ) UUT (
    .clk_6M          (clk_6M),
    .rstz            (rstz),
    .hdr_p           (hdr_p),
    .hdr             (hdr),
    .py_end_p        (py_end_p),
    .crc_ok          (crc_ok),
    .mic_ok          (mic_ok),
    .is_master       (is_master),
    .rx_slot_end_p   (rx_slot_end_p),
    .tx_slot_p       (tx_slot_p),
    .tx_lt_addr      (tx_lt_addr),
    .tx_pktype       (tx_pktype),
    .rx_arqn_vec     (rx_arqn_vec),
    .rx_flow_vec     (rx_flow_vec),
    .aclrx_buf_empty (aclrx_buf_empty),
    .new_conn_p      (new_conn_p),
    .new_conn_addr   (new_conn_addr),
    .rx_result       (rx_result),
    .tx_result       (tx_result),
    .ms_acltxcmd_p   (ms_acltxcmd_p),
    .rsp_flow        (rsp_flow)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  // DM1 DH1 DV DM3 DH3 DM5 DH5
  function automatic logic data_type(input logic [3:0] pt);
    return pt inside {4'h3, 4'h4, 4'h8, 4'ha, 4'hb, 4'he, 4'hf};
  endfunction

  // NULL POLL HV1 HV2 HV3 AUX1
  function automatic logic noseq_type(input logic [3:0] pt);
    return pt inside {4'h0, 4'h1, 4'h5, 4'h6, 4'h7, 4'h9};
  endfunction

  // results are compared as they appear
  always @(negedge clk_6M)
  begin
    if (rstz && rx_result.valid)
    begin
      check("rx_result", 32'(rx_result), 32'(rx_exp));
      rx_seen++;
    end
    if (rstz && tx_result.valid)
    begin
      check("tx_result", 32'(tx_result), 32'(tx_exp));
      tx_seen++;
    end
  end

  task automatic load_events();
    int    fd;
    int    f [11];
    string line;
    stim_t e;
    n_ev = 0;
    fd = $fopen("arq_stim.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the event file arq_stim.txt");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                  f[4], f[5], f[6], f[7], f[8], f[9], f[10]) == 11)
      begin
        e = '{kind: 4'(f[0]), addr: 3'(f[1]), pkt: 4'(f[2]), seqn: f[3][0], f1: f[4][0],
              f2: f[5][0], f3: f[6][0], f4: f[7][0], f5: f[8][0], master: f[9][0],
              exp: 2'(f[10])};
        ev[n_ev] = e;
        n_ev++;
      end
    end
    $fclose(fd);
  endtask

  // expected tx result and model update for one slot
  task automatic prep_tx(input lt_addr_t a, input logic [3:0] pt, input logic arqn,
                         input logic flow);
    logic       data;
    tx_choice_t ch;
    data = data_type(pt);
    ch = (!data || (arqn && flow)) ? TX_NEW : TX_OLD;
    tx_exp = '{valid: 1'b1, lt_addr: a, choice: ch, seqn: model[a].tx_seqn,
               arqn: model[a].arqn, src_flow: data ? flow : 1'b1};
    if (data && ch == TX_NEW)
      model[a].tx_seqn = ~model[a].tx_seqn;
    model[a].src_flow = data ? flow : 1'b1;
    tx_seen = 0;
  endtask

  task automatic wait_result(input int which);
    int n;
    n = 0;
    while (((which == 0) ? rx_seen : tx_seen) == 0 && n < 20)
    begin
      @(posedge clk_6M);
      n++;
    end
    if (((which == 0) ? rx_seen : tx_seen) == 0)
    begin
      errors++;
      $display("timeout waiting for the %s result", (which == 0) ? "rx" : "tx");
    end
  endtask

  task automatic rx_event(input stim_t e, input logic with_tx);
    link_entry_t cur;
    rx_verdict_t v;
    logic        fail;
    logic        need_py;
    cur = model[e.addr];
    fail = !(e.f1 && e.f2);
    need_py = !fail && e.f3 && data_type(e.pkt) && (e.seqn != cur.seqn_old);
    v = RX_NONE;
    if (fail)
    begin
      v = RX_REJECT;
      for (int i = 0; i < 8; i++)
        if (!e.master || i == int'(e.addr))
          model[i].arqn = 1'b0;
    end
    else if (e.f3 && data_type(e.pkt))
    begin
      if (e.seqn == cur.seqn_old)
      begin
        v = RX_IGNORE;
        model[e.addr].arqn = 1'b1;
      end
      else if (e.f4 && e.f5)
      begin
        v = RX_ACCEPT;
        model[e.addr].arqn = 1'b1;
        model[e.addr].seqn_old = e.seqn;
      end
      else
      begin
        v = RX_REJECT;
        model[e.addr].arqn = 1'b0;
      end
    end
    else if (e.f3 && noseq_type(e.pkt) && (e.seqn != cur.seqn_old))
    begin
      v = RX_REJECT;
      model[e.addr].arqn = 1'b0;
    end
    if (!e.master && (fail || !e.f3))
      sup_ref = 1'b1;
    check("stim rx verdict", 32'(v), 32'(e.exp));
    rx_exp = '{valid: 1'b1, lt_addr: e.addr, verdict: rx_verdict_t'(e.exp),
               arqn: model[e.addr].arqn, seqn_old: model[e.addr].seqn_old};
    rx_seen = 0;
    if (with_tx)
      prep_tx(e.addr ^ 3'd1, 4'h1, 1'b1, 1'b1);
    @(posedge clk_6M);
    #10;
    hdr_p = 1'b1;
    hdr = '{lt_addr: e.addr, pktype: pkt_type_t'(e.pkt), seqn: e.seqn, cac_ok: e.f1,
            hec_ok: e.f2, addressed: e.f3};
    is_master = e.master;
    crc_ok = e.f4;
    mic_ok = e.f5;
    if (with_tx)
    begin
      tx_slot_p = 1'b1;
      tx_lt_addr = e.addr ^ 3'd1;
      tx_pktype = PT_POLL;
      rx_arqn_vec = 8'hff;
      rx_flow_vec = 8'hff;
    end
    @(posedge clk_6M);
    #10;
    hdr_p = 1'b0;
    tx_slot_p = 1'b0;
    if (need_py)
    begin
      py_end_p = 1'b1;
      @(posedge clk_6M);
      #10;
      py_end_p = 1'b0;
    end
    // verdict is registered one cycle after the header or payload end
    check("rx_result.valid", 32'(rx_result.valid), 32'd1);
    wait_result(0);
    if (with_tx)
      wait_result(1);
    // slave header fail walks all eight links
    if (fail && !e.master)
      repeat (10) @(posedge clk_6M);
  endtask

  task automatic tx_event(input stim_t e);
    prep_tx(e.addr, e.pkt, e.f1, e.f2);
    check("stim tx choice", 32'(tx_exp.choice), 32'(e.exp));
    @(posedge clk_6M);
    #10;
    tx_slot_p = 1'b1;
    tx_lt_addr = e.addr;
    tx_pktype = pkt_type_t'(e.pkt);
    rx_arqn_vec = {8{e.f1}};
    rx_flow_vec = {8{e.f2}};
    aclrx_buf_empty = e.f3;
    @(posedge clk_6M);
    #10;
    tx_slot_p = 1'b0;
    wait_result(1);
    check("rsp_flow", 32'(rsp_flow), 32'(e.f3));
  endtask

  task automatic conn_event(input stim_t e);
    model[e.addr] = '{seqn_old: 1'b0, arqn: 1'b0, tx_seqn: 1'b1, src_flow: 1'b1};
    @(posedge clk_6M);
    #10;
    new_conn_p = 1'b1;
    new_conn_addr = e.addr;
    @(posedge clk_6M);
    #10;
    new_conn_p = 1'b0;
    repeat (2) @(posedge clk_6M);
  endtask

  task automatic slot_end_event(input stim_t e);
    check("stim ms_acltxcmd_p", 32'(!sup_ref), 32'(e.exp));
    @(posedge clk_6M);
    #10;
    rx_slot_end_p = 1'b1;
    @(negedge clk_6M);
    check("ms_acltxcmd_p", 32'(ms_acltxcmd_p), 32'(!sup_ref));
    sup_ref = 1'b0;
    @(posedge clk_6M);
    #10;
    rx_slot_end_p = 1'b0;
  endtask

  initial
  begin
    clk_6M = 1'b0;
    rstz = 1'b0;
    hdr_p = 1'b0;
    hdr = '0;
    py_end_p = 1'b0;
    crc_ok = 1'b0;
    mic_ok = 1'b0;
    is_master = 1'b1;
    rx_slot_end_p = 1'b0;
    tx_slot_p = 1'b0;
    tx_lt_addr = '0;
    tx_pktype = PT_NULL;
    rx_arqn_vec = '0;
    rx_flow_vec = '0;
    aclrx_buf_empty = 1'b1;
    new_conn_p = 1'b0;
    new_conn_addr = '0;
    errors = 0;
    checks = 0;
    sup_ref = 1'b0;
    rx_seen = 0;
    tx_seen = 0;
    rx_exp = '0;
    tx_exp = '0;
    for (int i = 0; i < 8; i++)
      model[i] = '{seqn_old: 1'b0, arqn: 1'b0, tx_seqn: 1'b1, src_flow: 1'b1};
    load_events();
    repeat (3) @(posedge clk_6M);
    #10;
    rstz = 1'b1;
    for (int k = 0; k < n_ev; k++)
    begin
      case (ev[k].kind)
        4'd1: rx_event(ev[k], 1'b0);
        4'd2: tx_event(ev[k]);
        4'd3: conn_event(ev[k]);
        4'd4: slot_end_event(ev[k]);
        4'd5: rx_event(ev[k], 1'b1);
        default:
        begin
          errors++;
          $display("unknown event kind %0d on event %0d", ev[k].kind, k);
        end
      endcase
    end
    repeat (2) @(posedge clk_6M);
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // bounded by the event count once the file is read
  initial
  begin
    wait (n_ev > 0);
    #(n_ev * 40 * 100);
    $display("run did not finish within %0d cycles", n_ev * 40);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== arq_stim.txt ====
# kind addr pkt seqn f1 f2 f3 f4 f5 master exp
# rx(1,5): f1..f5 = cac hec addressed crc mic; tx(2): f1..f3 = arqn flow buf_empty
1 0 4 1 1 1 1 1 1 1 1
1 0 4 1 1 1 1 1 1 1 2
1 1 3 1 1 1 1 0 1 1 3
1 1 a 1 1 1 1 1 0 1 3
1 1 f 1 1 1 1 1 1 1 1
1 2 1 1 1 1 1 0 0 1 3
1 2 0 0 1 1 1 0 0 1 0
1 3 4 1 1 1 1 1 1 1 1
1 0 4 0 1 0 1 1 1 1 3
2 3 1 0 1 1 1 0 0 1 1
4 0 0 0 0 0 0 0 0 1 1
2 0 4 0 1 1 1 0 0 1 1
2 0 4 0 1 1 1 0 0 1 1
2 0 4 0 0 1 0 0 0 1 2
2 0 4 0 1 0 1 0 0 1 2
2 0 3 0 1 1 1 0 0 1 1
2 1 1 0 0 0 0 0 0 1 1
2 1 b 0 1 0 1 0 0 1 2
1 2 4 1 1 1 0 1 1 0 0
4 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 1
1 4 4 1 1 1 1 1 1 0 1
1 4 4 0 0 1 1 1 1 0 3
4 0 0 0 0 0 0 0 0 0 0
2 1 1 0 1 1 1 0 0 0 1
2 3 0 0 1 1 1 0 0 0 1
3 0 0 0 0 0 0 0 0 0 0
2 0 1 0 1 1 1 0 0 0 1
1 0 4 1 1 1 1 1 1 1 1
5 5 4 1 1 1 1 1 1 1 1
5 5 4 1 1 1 1 1 1 1 2
4 0 0 0 0 0 0 0 0 1 1

// ==== flist.f ====
bt_arq_pkg.sv
link_state_table.sv
link_state_arbiter.sv
rx_arq_ctrl.sv
tx_arq_ctrl.sv
arq_flow_top.sv
arq_flow_assertions.sv
tb_arq_flow.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the ARQ flow testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_arq_flow -f flist.f -o tb_arq_flow > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_arq_flow > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
exit 1
